//--- verilog.f
+incdir+.
banked_mem_pkg.sv
bank_if.sv
bank_steer.sv
bank_channel.sv
response_merge.sv
banked_mem_top.sv
tb_banked_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the banked memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_banked_mem \
  -o sim_banked_mem

out=$(./obj_dir/sim_banked_mem)
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

//--- tb_banked_mem.sv
`include "banked_mem_settings.svh"
`default_nettype none

module tb_banked_mem;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 200;
  // Words per bank used by the directed tests
  localparam int WORDS        = 8;
  localparam int ORDER_READS  = 80;
  // Stress addresses span FILL_WORDS words per bank, all written first
  localparam int FILL_WORDS   = 32;
  localparam int STRESS_OPS   = 300;
  localparam int NUM_OPS      = 2 * WORDS + 4 * WORDS + ORDER_READS
                              + `NUM_BANKS * FILL_WORDS + STRESS_OPS;
  localparam int WATCHDOG_CYCLES = NUM_OPS * (`REFRESH_INTERVAL + 20)
                                 + IDLE_CYCLES + RESET_CYCLES;
  localparam int DRAIN_LIMIT  = 4 * (`REFRESH_INTERVAL + `REFRESH_CYCLES);

  logic                     pClk;
  logic                     rst_n;
  banked_mem_pkg::bank_id_t bank_select;
  banked_mem_pkg::addr_t    address;
  logic                     read;
  logic                     write;
  banked_mem_pkg::data_t    writedata;
  banked_mem_pkg::byte_en_t byteenable;
  logic                     waitrequest;
  banked_mem_pkg::data_t    readdata;
  logic                     readdatavalid;

  // Reference model and expected returns in acceptance order
  banked_mem_pkg::data_t ref_mem [`NUM_BANKS][1 << `ADDR_WIDTH];
  banked_mem_pkg::data_t exp_q [$];

  int          errors = 0;
  int          checks = 0;
  int          reads_total = 0;
  int          rdv_total = 0;
  logic [31:0] lfsr_state;

  banked_mem_top banked_mem_top_i (
    .pClk          (pClk),
    .rst_n         (rst_n),
    .bank_select   (bank_select),
    .address       (address),
    .read          (read),
    .write         (write),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .waitrequest   (waitrequest),
    .readdata      (readdata),
    .readdatavalid (readdatavalid)
  );

  initial begin
    pClk = 1'b0;
    forever #(CLK_PERIOD / 2) pClk = ~pClk;
  end

  // Hard limit on run time
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ============================================================
  // Helpers
  // ============================================================

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hd000_0001) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Spread the directed words over the whole address range
  function automatic banked_mem_pkg::addr_t word_addr(input int i);
    return banked_mem_pkg::addr_t'(i * 129);
  endfunction

  // Fill word keyed on bank and full address
  function automatic banked_mem_pkg::data_t fill_word(input banked_mem_pkg::bank_id_t b,
                                                      input banked_mem_pkg::addr_t a);
    logic [15:0] key;
    key = 16'({b, a});
    return {key, ~key, key ^ 16'h5a5a, 16'hc3c3 + key};
  endfunction

  task automatic check_data(input banked_mem_pkg::data_t got, input banked_mem_pkg::data_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAILED",
             errors - err_before);
  endtask

  // One Avalon command, held until waitrequest is low at the negedge
  task automatic issue_cmd(input logic is_write, input banked_mem_pkg::bank_id_t bank,
                           input banked_mem_pkg::addr_t addr,
                           input banked_mem_pkg::data_t wdata,
                           input banked_mem_pkg::byte_en_t be);
    logic accepted;
    accepted = 1'b0;
    @(posedge pClk);
    bank_select <= bank;
    address     <= addr;
    read        <= ~is_write;
    write       <= is_write;
    writedata   <= wdata;
    byteenable  <= be;
    while (!accepted) begin
      @(negedge pClk);
      accepted = !waitrequest;
    end
    // Accepted on the coming edge so update the model now
    if (is_write) begin
      for (int i = 0; i < `BYTE_EN_WIDTH; i++) begin
        if (be[i]) ref_mem[bank][addr][8*i +: 8] = wdata[8*i +: 8];
      end
    end else begin
      exp_q.push_back(ref_mem[bank][addr]);
      reads_total++;
    end
  endtask

  task automatic end_cmds();
    @(posedge pClk);
    read  <= 1'b0;
    write <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge pClk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Read data missing: %0d reads still outstanding after %0d cycles",
               exp_q.size(), DRAIN_LIMIT);
      exp_q.delete();
    end
  endtask

  // Every return pops the oldest expected word
  task automatic watch_returns();
    banked_mem_pkg::data_t expected;
    forever begin
      @(negedge pClk);
      if (rst_n && readdatavalid) begin
        rdv_total++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected readdatavalid at %0t ns with no read outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          check_data(readdata, expected, $sformatf("read return %0d", rdv_total));
        end
      end
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic test_idle();
    int err_before;
    int rdv_seen;
    int wait_seen;
    err_before = errors;
    rdv_seen   = 0;
    wait_seen  = 0;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge pClk);
      if (readdatavalid) rdv_seen++;
      if (waitrequest) wait_seen++;
    end
    check_count(rdv_seen, 0, "idle readdatavalid cycles");
    check_count(wait_seen, 0, "idle waitrequest cycles");
    report_test("idle after reset", err_before);
  endtask

  task automatic test_write_read();
    int err_before;
    err_before = errors;
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b1, '0, word_addr(i), banked_mem_pkg::data_t'(rand_bits(64)), '1);
    end
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b0, '0, word_addr(i), '0, '0);
    end
    end_cmds();
    wait_drain();
    report_test("write then read in bank 0", err_before);
  endtask

  task automatic test_byte_enables();
    int err_before;
    err_before = errors;
    // Full base words in bank 1, then partial overlays
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b1, banked_mem_pkg::bank_id_t'(1), word_addr(i),
                banked_mem_pkg::data_t'(rand_bits(64)), '1);
    end
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b1, banked_mem_pkg::bank_id_t'(1), word_addr(i),
                banked_mem_pkg::data_t'(rand_bits(64)),
                banked_mem_pkg::byte_en_t'(rand_bits(`BYTE_EN_WIDTH)));
    end
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b0, banked_mem_pkg::bank_id_t'(1), word_addr(i), '0, '0);
    end
    // Bank 0 must still hold the words of the previous test
    for (int i = 0; i < WORDS; i++) begin
      issue_cmd(1'b0, '0, word_addr(i), '0, '0);
    end
    end_cmds();
    wait_drain();
    report_test("byte enables and bank isolation", err_before);
  endtask

  task automatic test_order();
    int                       err_before;
    banked_mem_pkg::bank_id_t bank;
    err_before = errors;
    // Longer than one refresh period so a stall always falls inside
    for (int i = 0; i < ORDER_READS; i++) begin
      if (i < ORDER_READS / 2) bank = banked_mem_pkg::bank_id_t'(i % 2);
      else bank = (i % 4 == 3) ? banked_mem_pkg::bank_id_t'(1) : '0;
      issue_cmd(1'b0, bank, word_addr(i % WORDS), '0, '0);
    end
    end_cmds();
    wait_drain();
    report_test("ordering across banks", err_before);
  endtask

  task automatic test_stress();
    int                       err_before;
    int                       reads_before;
    int                       rdv_before;
    logic                     is_write;
    banked_mem_pkg::bank_id_t bank;
    banked_mem_pkg::addr_t    addr;
    err_before   = errors;
    reads_before = reads_total;
    rdv_before   = rdv_total;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int a = 0; a < FILL_WORDS; a++) begin
        issue_cmd(1'b1, banked_mem_pkg::bank_id_t'(b), banked_mem_pkg::addr_t'(a),
                  fill_word(banked_mem_pkg::bank_id_t'(b), banked_mem_pkg::addr_t'(a)), '1);
      end
    end
    for (int n = 0; n < STRESS_OPS; n++) begin
      is_write = 1'(rand_bits(1));
      bank     = banked_mem_pkg::bank_id_t'(rand_bits(`BANK_SEL_WIDTH));
      addr     = banked_mem_pkg::addr_t'(rand_bits($clog2(FILL_WORDS)));
      issue_cmd(is_write, bank, addr, banked_mem_pkg::data_t'(rand_bits(64)),
                banked_mem_pkg::byte_en_t'(rand_bits(`BYTE_EN_WIDTH)));
    end
    end_cmds();
    wait_drain();
    check_count(rdv_total - rdv_before, reads_total - reads_before, "stress return count");
    report_test("random stress", err_before);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    rst_n       = 1'b0;
    bank_select = '0;
    address     = '0;
    read        = 1'b0;
    write       = 1'b0;
    writedata   = '0;
    byteenable  = '0;
    lfsr_state  = 32'ha940_7d2d;
    fork
      watch_returns();
    join_none
    repeat (RESET_CYCLES) @(posedge pClk);
    rst_n <= 1'b1;
    test_idle();
    test_write_read();
    test_byte_enables();
    test_order();
    test_stress();
    check_count(rdv_total, reads_total, "total return count");
    $display("Checks: %0d, errors: %0d, reads: %0d, returns: %0d",
             checks, errors, reads_total, rdv_total);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- banked_mem_top.sv
`include "banked_mem_settings.svh"
`default_nettype none

module banked_mem_top (
  input  wire                           pClk,
  input  wire                           rst_n,
  // Bank select level from the host
  input  wire banked_mem_pkg::bank_id_t bank_select,
  // Avalon slave port with burst count fixed at one
  input  wire banked_mem_pkg::addr_t    address,
  input  wire                           read,
  input  wire                           write,
  input  wire banked_mem_pkg::data_t    writedata,
  input  wire banked_mem_pkg::byte_en_t byteenable,
  output logic                          waitrequest,
  output banked_mem_pkg::data_t         readdata,
  output logic                          readdatavalid
);

  // Read order tracking between steer and merge
  logic                     read_issue;
  banked_mem_pkg::bank_id_t read_bank;
  logic                     order_full;

  // One command and one response interface per bank
  bank_cmd_if cmd_if [`NUM_BANKS] ();
  bank_rsp_if rsp_if [`NUM_BANKS] ();

  // ============================================================
  // Host steering
  // ============================================================

  bank_steer bank_steer_i (
    .pClk        (pClk),
    .rst_n       (rst_n),
    .bank_select (bank_select),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .waitrequest (waitrequest),
    .cmd         (cmd_if),
    .read_issue  (read_issue),
    .read_bank   (read_bank),
    .order_full  (order_full)
  );

  // ============================================================
  // Bank channels
  // ============================================================

  genvar b;
  generate
    for (b = 0; b < `NUM_BANKS; b++) begin : g_bank
      bank_channel bank_channel_i (
        .pClk  (pClk),
        .rst_n (rst_n),
        .cmd   (cmd_if[b]),
        .rsp   (rsp_if[b])
      );
    end
  endgenerate

  // In order read return
  response_merge response_merge_i (
    .pClk          (pClk),
    .rst_n         (rst_n),
    .read_issue    (read_issue),
    .read_bank     (read_bank),
    .order_full    (order_full),
    .rsp           (rsp_if),
    .readdata      (readdata),
    .readdatavalid (readdatavalid)
  );

endmodule

`default_nettype wire

//--- response_merge.sv
`include "banked_mem_settings.svh"
`default_nettype none

module response_merge (
  input  wire                           pClk,
  input  wire                           rst_n,
  // Read issue order from the steer
  input  wire                           read_issue,
  input  wire banked_mem_pkg::bank_id_t read_bank,
  output logic                          order_full,
  // Bank responses
  bank_rsp_if.merge                     rsp [`NUM_BANKS],
  // Avalon host read return
  output banked_mem_pkg::data_t         readdata,
  output logic                          readdatavalid
);

  localparam int OPTR_W = $clog2(`MAX_OUTSTANDING);
  localparam banked_mem_pkg::order_cnt_t MAX_CNT =
    banked_mem_pkg::order_cnt_t'(`MAX_OUTSTANDING);

  // Order queue holds the bank of every read in flight
  banked_mem_pkg::bank_id_t   order_q [`MAX_OUTSTANDING];
  logic [OPTR_W-1:0]          ord_wr_ptr;
  logic [OPTR_W-1:0]          ord_rd_ptr;
  banked_mem_pkg::order_cnt_t ord_count;

  banked_mem_pkg::bank_id_t   head_bank;
  logic [`NUM_BANKS-1:0]      buf_empty;
  banked_mem_pkg::data_t      buf_head [`NUM_BANKS];
  logic                       pop;

  assign head_bank  = order_q[ord_rd_ptr];
  assign order_full = (ord_count == MAX_CNT);

  // Return only when the oldest read has its data buffered
  assign pop = (ord_count != '0) && !buf_empty[head_bank];

  // ============================================================
  // Order queue
  // ============================================================

  always_ff @(posedge pClk or negedge rst_n) begin
    if (!rst_n) begin
      ord_wr_ptr <= '0;
      ord_rd_ptr <= '0;
      ord_count  <= '0;
    end else begin
      if (read_issue) ord_wr_ptr <= ord_wr_ptr + 1'b1;
      if (pop) ord_rd_ptr <= ord_rd_ptr + 1'b1;
      if (read_issue && !pop) ord_count <= ord_count + 1'b1;
      else if (!read_issue && pop) ord_count <= ord_count - 1'b1;
    end
  end

  always_ff @(posedge pClk) begin
    if (read_issue) order_q[ord_wr_ptr] <= read_bank;
  end

  // ============================================================
  // Per bank response buffers
  // ============================================================

  genvar b;
  generate
    for (b = 0; b < `NUM_BANKS; b++) begin : g_buf
      banked_mem_pkg::data_t      buf_data [`MAX_OUTSTANDING];
      logic [OPTR_W-1:0]          buf_wr_ptr;
      logic [OPTR_W-1:0]          buf_rd_ptr;
      banked_mem_pkg::order_cnt_t buf_count;
      logic                       buf_pop;

      assign buf_pop      = pop && (head_bank == banked_mem_pkg::bank_id_t'(b));
      assign buf_empty[b] = (buf_count == '0);
      assign buf_head[b]  = buf_data[buf_rd_ptr];

      // Push on each bank response, pop when this bank heads the order
      always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
          buf_wr_ptr <= '0;
          buf_rd_ptr <= '0;
          buf_count  <= '0;
        end else begin
          if (rsp[b].rsp_valid) buf_wr_ptr <= buf_wr_ptr + 1'b1;
          if (buf_pop) buf_rd_ptr <= buf_rd_ptr + 1'b1;
          if (rsp[b].rsp_valid && !buf_pop) buf_count <= buf_count + 1'b1;
          else if (!rsp[b].rsp_valid && buf_pop) buf_count <= buf_count - 1'b1;
        end
      end

      always_ff @(posedge pClk) begin
        if (rsp[b].rsp_valid) buf_data[buf_wr_ptr] <= rsp[b].rsp_data;
      end
    end
  endgenerate

  // Registered return to the host
  always_ff @(posedge pClk or negedge rst_n) begin
    if (!rst_n) begin
      readdatavalid <= 1'b0;
    end else begin
      readdatavalid <= pop;
    end
  end

  always_ff @(posedge pClk) begin
    if (pop) readdata <= buf_head[head_bank];
  end

endmodule

`default_nettype wire

//--- bank_channel.sv
`include "banked_mem_settings.svh"
`default_nettype none

module bank_channel (
  input  wire       pClk,
  input  wire       rst_n,
  bank_cmd_if.bank  cmd,
  bank_rsp_if.bank  rsp
);

  localparam int QPTR_W = $clog2(`CMD_QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(`CMD_QUEUE_DEPTH + 1);
  localparam int RCNT_W = $clog2(`REFRESH_INTERVAL);
  localparam int LAT    = `BANK_READ_LATENCY;

  localparam logic [QCNT_W-1:0] Q_DEPTH  = QCNT_W'(`CMD_QUEUE_DEPTH);
  localparam logic [RCNT_W-1:0] ACT_LAST = RCNT_W'(`REFRESH_INTERVAL - 1);
  localparam logic [RCNT_W-1:0] REF_LAST = RCNT_W'(`REFRESH_CYCLES - 1);

  // Command queue storage
  logic                     q_write   [`CMD_QUEUE_DEPTH];
  banked_mem_pkg::addr_t    q_addr    [`CMD_QUEUE_DEPTH];
  banked_mem_pkg::data_t    q_wdata   [`CMD_QUEUE_DEPTH];
  banked_mem_pkg::byte_en_t q_byte_en [`CMD_QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] q_count;

  // Refresh FSM
  banked_mem_pkg::refresh_state_t state;
  logic [RCNT_W-1:0]              refresh_cnt;

  // Local array standing in for the DDR bank
  banked_mem_pkg::data_t mem [1 << `ADDR_WIDTH];

  // Read pipeline
  logic [LAT-1:0]        pipe_valid;
  banked_mem_pkg::data_t pipe_data [LAT];

  logic serve;
  logic serve_rd;

  // Head of queue is served once per cycle outside refresh
  assign serve    = (state == banked_mem_pkg::ST_ACTIVE) && (q_count != '0);
  assign serve_rd = serve & ~q_write[rd_ptr];

  assign cmd.queue_full = (q_count == Q_DEPTH);

  // ============================================================
  // Command queue
  // ============================================================

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge pClk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (cmd.cmd_valid) wr_ptr <= wr_ptr + 1'b1;
      if (serve) rd_ptr <= rd_ptr + 1'b1;
      if (cmd.cmd_valid && !serve) q_count <= q_count + 1'b1;
      else if (!cmd.cmd_valid && serve) q_count <= q_count - 1'b1;
    end
  end

  always_ff @(posedge pClk) begin
    if (cmd.cmd_valid) begin
      q_write[wr_ptr]   <= cmd.cmd_write;
      q_addr[wr_ptr]    <= cmd.cmd_addr;
      q_wdata[wr_ptr]   <= cmd.cmd_wdata;
      q_byte_en[wr_ptr] <= cmd.cmd_byte_en;
    end
  end

  // ============================================================
  // Refresh FSM
  // ============================================================

  always_ff @(posedge pClk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= banked_mem_pkg::ST_ACTIVE;
      refresh_cnt <= '0;
    end else begin
      case (state)
        banked_mem_pkg::ST_ACTIVE: begin
          // Interval elapsed so stall the queue
          if (refresh_cnt == ACT_LAST) begin
            state       <= banked_mem_pkg::ST_REFRESH;
            refresh_cnt <= '0;
          end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
          end
        end
        default: begin
          if (refresh_cnt == REF_LAST) begin
            state       <= banked_mem_pkg::ST_ACTIVE;
            refresh_cnt <= '0;
          end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // ============================================================
  // Array and read pipeline
  // ============================================================

  always_ff @(posedge pClk) begin
    // Byte lane write of the served entry
    if (serve && q_write[rd_ptr]) begin
      for (int i = 0; i < `BYTE_EN_WIDTH; i++) begin
        if (q_byte_en[rd_ptr][i]) begin
          mem[q_addr[rd_ptr]][8*i +: 8] <= q_wdata[rd_ptr][8*i +: 8];
        end
      end
    end
    // Stage 0 takes the array word and later stages shift
    pipe_data[0] <= mem[q_addr[rd_ptr]];
    for (int i = 1; i < LAT; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  always_ff @(posedge pClk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= serve_rd;
      for (int i = 1; i < LAT; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  // Response leaves from the last stage
  assign rsp.rsp_valid = pipe_valid[LAT-1];
  assign rsp.rsp_data  = pipe_data[LAT-1];

endmodule

`default_nettype wire

//--- bank_steer.sv
`include "banked_mem_settings.svh"
`default_nettype none

module bank_steer (
  input  wire                             pClk,
  input  wire                             rst_n,
  // Avalon host side
  input  wire banked_mem_pkg::bank_id_t   bank_select,
  input  wire banked_mem_pkg::addr_t      address,
  input  wire                             read,
  input  wire                             write,
  input  wire banked_mem_pkg::data_t      writedata,
  input  wire banked_mem_pkg::byte_en_t   byteenable,
  output logic                            waitrequest,
  // One command port per bank
  bank_cmd_if.steer                       cmd [`NUM_BANKS],
  // Read order tracking in the merge
  output logic                            read_issue,
  output banked_mem_pkg::bank_id_t        read_bank,
  input  wire                             order_full
);

  logic [`NUM_BANKS-1:0] bank_full;
  logic                  accept;

  // Stall on a full bank queue or when no more reads may be in flight
  // The host holds bank_select steady while stalled
  assign waitrequest = bank_full[bank_select] | (order_full & read);
  assign accept      = (read | write) & ~waitrequest;

  // Every accepted read gets a slot in the order queue
  assign read_issue = accept & read;
  assign read_bank  = bank_select;

  // ============================================================
  // Per bank decode
  // ============================================================

  genvar b;
  generate
    for (b = 0; b < `NUM_BANKS; b++) begin : g_bank
      assign bank_full[b] = cmd[b].queue_full;

      // One hot strobe and shared payload
      assign cmd[b].cmd_valid   = accept & (bank_select == banked_mem_pkg::bank_id_t'(b));
      assign cmd[b].cmd_write   = write;
      assign cmd[b].cmd_addr    = address;
      assign cmd[b].cmd_wdata   = writedata;
      assign cmd[b].cmd_byte_en = byteenable;
    end
  endgenerate

endmodule

`default_nettype wire

//--- bank_if.sv
`default_nettype none

// ============================================================
// Command path from the steer into one bank
// ============================================================

interface bank_cmd_if;

  // Single beat command
  logic                     cmd_valid;
  logic                     cmd_write;
  banked_mem_pkg::addr_t    cmd_addr;
  banked_mem_pkg::data_t    cmd_wdata;
  banked_mem_pkg::byte_en_t cmd_byte_en;

  // Bank queue has no free entry
  logic                     queue_full;

  modport steer (
    output cmd_valid, cmd_write, cmd_addr, cmd_wdata, cmd_byte_en,
    input  queue_full
  );

  modport bank (
    input  cmd_valid, cmd_write, cmd_addr, cmd_wdata, cmd_byte_en,
    output queue_full
  );

endinterface

// ============================================================
// Read response path from one bank into the merge
// ============================================================

interface bank_rsp_if;

  // One cycle pulse with its data word and no back-pressure
  logic                  rsp_valid;
  banked_mem_pkg::data_t rsp_data;

  modport bank (output rsp_valid, rsp_data);

  modport merge (input rsp_valid, rsp_data);

endinterface

`default_nettype wire

//--- banked_mem_pkg.sv
`include "banked_mem_settings.svh"
`default_nettype none

package banked_mem_pkg;

  // Host data word and its byte enables
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`BYTE_EN_WIDTH-1:0] byte_en_t;

  // Word address inside one bank
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Bank index as carried by bank_select
  typedef logic [`BANK_SEL_WIDTH-1:0] bank_id_t;

  // Outstanding read count with room for the full value
  typedef logic [$clog2(`MAX_OUTSTANDING):0] order_cnt_t;

  // Per bank refresh FSM
  typedef enum logic {
    ST_ACTIVE,
    ST_REFRESH
  } refresh_state_t;

endpackage

`default_nettype wire

//--- banked_mem_settings.svh
`ifndef BANKED_MEM_SETTINGS_SVH
`define BANKED_MEM_SETTINGS_SVH

// Host data word and its byte lanes
`define DATA_WIDTH 64
`define BYTE_EN_WIDTH 8

// Word address inside one bank
`define ADDR_WIDTH 10

// Bank count and bank index width (use 2 bits for four banks)
`define NUM_BANKS 2
`define BANK_SEL_WIDTH 1

// Queue sizes
`define CMD_QUEUE_DEPTH 4
`define MAX_OUTSTANDING 8

// Bank read pipeline and refresh timing in pClk cycles
`define BANK_READ_LATENCY 2
`define REFRESH_INTERVAL 64
`define REFRESH_CYCLES 8

`endif
